//--- src.f
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_control.sv
verilog/fetch_inflight_counter.sv
verilog/fetch_attr_fifo.sv
verilog/ilocal_mem_unit.sv
verilog/ibus_unit.sv
verilog/fetch_top.sv
verification/fetch_tb_mem.sv
verification/fetch_tb.sv

//--- verification/fetch_tb.sv
// Rows run in order and each waits for its completion count; a stalled DUT ends in a timeout
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int    NUM_ROWS    = 10;
    localparam int    RANDOM_SEED = 58833;
    localparam addr_t BUS_XOR     = 32'h5A5A_0000;

    logic  clk;
    logic  rst;
    logic  fetch_flush;
    addr_t flush_pc;
    logic  fetch_hold;
    logic  fetch_complete;
    addr_t fetch_pc;
    addr_t fetch_instruction;
    logic  fetch_ok;
    logic               bram_en;
    logic [LMEM_AW-1:0] bram_addr;
    addr_t              bram_data;
    logic               bus_req;
    addr_t              bus_addr;
    logic               bus_ack;
    addr_t              bus_data;

    // Stimulus table with one column per field
    int    row_hold  [NUM_ROWS];
    logic  row_flush [NUM_ROWS];
    addr_t row_pc    [NUM_ROWS];
    int    row_count [NUM_ROWS];
    logic  row_ok    [NUM_ROWS];

    // Scoreboard state
    addr_t exp_pc          = RESET_VEC;
    logic  exp_ok          = 1'b1;
    logic  next_ok         = 1'b1;
    logic  stopped         = 1'b0;
    int    completions     = 0;
    int    checks          = 0;
    int    errors          = 0;
    int    watchdog_cycles = 0;

    fetch_top dut0 (
        .clk (clk), .rst (rst),
        .fetch_flush (fetch_flush), .flush_pc (flush_pc), .fetch_hold (fetch_hold),
        .fetch_complete (fetch_complete), .fetch_pc (fetch_pc),
        .fetch_instruction (fetch_instruction), .fetch_ok (fetch_ok),
        .bram_en (bram_en), .bram_addr (bram_addr), .bram_data (bram_data),
        .bus_req (bus_req), .bus_addr (bus_addr), .bus_ack (bus_ack), .bus_data (bus_data)
    );

    bram_model bram0 (
        .clk (clk), .rst (rst), .bram_en (bram_en), .bram_addr (bram_addr),
        .bram_data (bram_data)
    );

    ibus_model #(.SEED (RANDOM_SEED), .DATA_XOR (BUS_XOR)) bus0 (
        .clk (clk), .rst (rst), .bus_req (bus_req), .bus_addr (bus_addr),
        .bus_ack (bus_ack), .bus_data (bus_data)
    );

    always #20 clk = ~clk;

    // Word each memory model returns for a fetch address
    function automatic addr_t expected_word(input addr_t addr);
        if ((addr >= IBUS_BASE) && (addr <= IBUS_LAST)) begin
            return addr ^ BUS_XOR;
        end
        return ~addr;
    endfunction

    task automatic set_row(input int idx, input int hold, input logic flush, input addr_t pc,
                           input int count, input logic ok);
        row_hold[idx]  = hold;
        row_flush[idx] = flush;
        row_pc[idx]    = pc;
        row_count[idx] = count;
        row_ok[idx]    = ok;
    endtask

    //////////////////////////////
    // Scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            if (fetch_complete === 1'b1) begin
                completions = completions + 1;
                checks = checks + 3;
                assert (!stopped) else begin
                    errors = errors + 1;
                    $display("Completion at pc %h arrived while fetching was stopped", fetch_pc);
                end
                assert (fetch_pc === exp_pc) else begin
                    errors = errors + 1;
                    $display("** Error: fetch_pc is %h, expected %h", fetch_pc, exp_pc);
                end
                assert (fetch_ok === exp_ok) else begin
                    errors = errors + 1;
                    $display("** Error: fetch_ok is %h, expected %h", fetch_ok, exp_ok);
                end
                if (exp_ok) begin
                    checks = checks + 1;
                    assert (fetch_instruction === expected_word(exp_pc)) else begin
                        errors = errors + 1;
                        $display("** Error: fetch_instruction is %h, expected %h",
                                 fetch_instruction, expected_word(exp_pc));
                    end
                end
                // A faulted fetch stops the stream until the next flush
                if (!exp_ok) begin
                    stopped = 1'b1;
                end
                exp_pc = exp_pc + 32'd4;
            end
            // Same-cycle completion belongs to the old stream
            if (fetch_flush) begin
                exp_pc  = flush_pc;
                exp_ok  = next_ok;
                stopped = 1'b0;
            end
        end
    end

    task automatic run_row(input int idx);
        int base;
        int held;
        int err_before;
        err_before = errors;
        base = completions;
        if (row_hold[idx] > 0) begin
            fetch_hold = 1'b1;
            repeat (row_hold[idx]) @(negedge clk);
            fetch_hold = 1'b0;
            held = completions - base;
            checks = checks + 1;
            assert (held <= MAX_INFLIGHT) else begin
                errors = errors + 1;
                $display("Too many completions while held: %0d, limit %0d", held, MAX_INFLIGHT);
            end
        end
        if (row_flush[idx]) begin
            fetch_flush = 1'b1;
            flush_pc    = row_pc[idx];
            next_ok     = row_ok[idx];
            @(negedge clk);
            fetch_flush = 1'b0;
            base = completions;
        end
        while ((completions - base) < row_count[idx]) begin
            @(negedge clk);
        end
        $display("Row %0d done: %0d completions, %0d errors", idx, row_count[idx],
                 errors - err_before);
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_flush = 1'b0;
        flush_pc    = '0;
        fetch_hold  = 1'b0;
        //      row hold flush  flush pc       count ok
        set_row(0,  0,   1'b0, 32'h0000_0000, 8,    1'b1);
        set_row(1,  0,   1'b1, 32'h8000_0100, 6,    1'b1);
        set_row(2,  0,   1'b1, 32'h0000_0200, 6,    1'b1);
        set_row(3,  0,   1'b1, 32'h4000_0000, 1,    1'b0);
        set_row(4,  8,   1'b1, 32'h0000_0040, 4,    1'b1);
        set_row(5,  6,   1'b0, 32'h0000_0000, 5,    1'b1);
        set_row(6,  0,   1'b1, 32'h8000_0200, 4,    1'b1);
        set_row(7,  10,  1'b0, 32'h0000_0000, 4,    1'b1);
        set_row(8,  0,   1'b1, 32'hFFFF_FFF0, 1,    1'b0);
        set_row(9,  6,   1'b1, 32'h8000_0000, 5,    1'b1);
        // Worst case bus round trip per completion, plus holds and per-row slack
        for (int i = 0; i < NUM_ROWS; i++) begin
            watchdog_cycles = watchdog_cycles + row_count[i] * 8 + row_hold[i] + 10;
        end
        watchdog_cycles = watchdog_cycles + 50;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Summary: %0d rows, %0d completions, %0d checks, %0d errors",
                 NUM_ROWS, completions, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the fetch stage stopped completing", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/fetch_tb_mem.sv
// Simulation models only; the bus model serves one request at a time and drives on the falling edge
`timescale 1ns/100ps
`default_nettype none

// Block RAM returning the inverted byte address, one cycle after bram_en
module bram_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bram_en,
    input  logic [fetch_pkg::LMEM_AW-1:0] bram_addr,
    output fetch_pkg::addr_t              bram_data
);
    import fetch_pkg::*;

    logic               rd_pending;
    logic [LMEM_AW-1:0] rd_word;

    initial begin
        bram_data = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= bram_en;
            rd_word    <= bram_addr;
        end
    end

    // Output changes mid cycle, stable before the next rising edge
    always @(negedge clk) begin
        if (rd_pending) begin
            bram_data <= ~(LMEM_BASE + (addr_t'(rd_word) << 2));
        end
    end

endmodule

// Instruction bus answering each request after 1 to 4 cycles
module ibus_model #(
    parameter int               SEED     = 1,
    parameter fetch_pkg::addr_t DATA_XOR = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             bus_req,
    input  fetch_pkg::addr_t bus_addr,
    output logic             bus_ack,
    output fetch_pkg::addr_t bus_data
);
    integer seed = SEED;
    logic   busy;
    int     wait_cycles;

    initial begin
        bus_ack  = 1'b0;
        bus_data = '0;
        busy     = 1'b0;
    end

    always @(negedge clk) begin
        if (rst) begin
            busy = 1'b0;
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= 1'b0;
            if (bus_req) begin
                wait_cycles = 1 + ({$random(seed)} % 4);
                busy = 1'b1;
            end else if (busy) begin
                wait_cycles = wait_cycles - 1;
                if (wait_cycles == 0) begin
                    bus_ack  <= 1'b1;
                    bus_data <= bus_addr ^ DATA_XOR;
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_attr_fifo.sv
// Storage has no reset; data_out is only meaningful while valid is high
`timescale 1ns/100ps
`default_nettype none

module fetch_attr_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     full,
    output logic     valid
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] result;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    assign data_out = entries[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign valid    = (count != '0);

    //////////////////////////////
    // Checks
    overflow_check: assert property (@(posedge clk) disable iff (rst) push |-> ~full)
        else $error("Push into full FIFO");

    underflow_check: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("Pop from empty FIFO");

endmodule

`default_nettype wire

//--- verilog/fetch_control.sv
// Both units must be ready to issue; an unmapped address stops fetching until the next flush
`timescale 1ns/100ps
`default_nettype none

module fetch_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_flush,
    input  logic                  fetch_hold,
    input  logic                  fifo_full,
    input  logic                  fifo_valid,
    input  logic                  lmem_ready,
    input  logic                  ibus_ready,
    input  logic                  lmem_data_valid,
    input  logic                  ibus_data_valid,
    input  logic                  discard,
    input  fetch_pkg::addr_t      pc,
    input  fetch_pkg::addr_t      lmem_data,
    input  fetch_pkg::addr_t      ibus_data,
    input  fetch_pkg::fetch_attr_t head,
    output logic                  new_request,
    output logic                  fault_push,
    output logic                  pop,
    output logic                  lmem_request,
    output logic                  ibus_request,
    output fetch_pkg::fetch_attr_t attr_in,
    output logic                  fetch_complete,
    output logic                  fetch_ok,
    output fetch_pkg::addr_t      fetch_pc,
    output fetch_pkg::addr_t      fetch_instruction
);
    import fetch_pkg::*;

    typedef enum logic {
        FETCHING,
        FAULT_STOP
    } state_t;

    state_t state;
    logic   lmem_match;
    logic   ibus_match;
    logic   address_valid;
    logic   issue_ok;
    logic   head_data_valid;

    //////////////////////////////
    // Address decode
    assign lmem_match    = (pc >= LMEM_BASE) && (pc <= LMEM_LAST);
    assign ibus_match    = (pc >= IBUS_BASE) && (pc <= IBUS_LAST);
    assign address_valid = lmem_match | ibus_match;

    // Issue gating common to real requests and faults
    assign issue_ok = ~fetch_hold & ~fifo_full & ~fetch_flush & (state == FETCHING);

    assign new_request  = issue_ok & address_valid & lmem_ready & ibus_ready;
    assign fault_push   = issue_ok & ~address_valid;
    assign lmem_request = new_request & lmem_match;
    assign ibus_request = new_request & ibus_match;

    assign attr_in = '{
        pc:            pc,
        address_valid: address_valid,
        unit_sel:      ibus_match ? UNIT_IBUS : UNIT_LMEM
    };

    // Fault stop holds until a flush redirects the PC
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCHING;
        end else if (fetch_flush) begin
            state <= FETCHING;
        end else if (fault_push) begin
            state <= FAULT_STOP;
        end
    end

    //////////////////////////////
    // Completion
    assign head_data_valid = (head.unit_sel == UNIT_IBUS) ? ibus_data_valid : lmem_data_valid;

    // Faulted entries retire as soon as they reach the head
    assign pop = fifo_valid & (~head.address_valid | head_data_valid);

    assign fetch_complete    = pop & ~discard;
    assign fetch_ok          = head.address_valid;
    assign fetch_pc          = head.pc;
    assign fetch_instruction = (head.unit_sel == UNIT_IBUS) ? ibus_data : lmem_data;

    // Responses must line up with the oldest outstanding entry
    unit_order_check: assert property (@(posedge clk) disable iff (rst)
        (lmem_data_valid | ibus_data_valid) |->
            (fifo_valid && head.address_valid && head_data_valid))
        else $error("Unit data valid without a matching FIFO head");

endmodule

`default_nettype wire

//--- verilog/fetch_inflight_counter.sv
// Flush count snapshots the inflight count; every pop while it is non-zero is discarded
`timescale 1ns/100ps
`default_nettype none

module fetch_inflight_counter (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  logic fetch_flush,
    output logic discard
);
    import fetch_pkg::*;

    logic [INFLIGHT_W-1:0] inflight_count;
    logic [INFLIGHT_W-1:0] inflight_count_next;
    logic [INFLIGHT_W-1:0] flush_count;

    assign inflight_count_next = inflight_count + INFLIGHT_W'(push) - INFLIGHT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            inflight_count <= inflight_count_next;
        end
    end

    // Old requests still complete after a flush, so count them down
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (fetch_flush) begin
            flush_count <= inflight_count_next;
        end else if ((flush_count != '0) && pop) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    assign discard = (flush_count != '0);

    //////////////////////////////
    // Checks
    inflight_limit_check: assert property (@(posedge clk) disable iff (rst)
        inflight_count <= INFLIGHT_W'(MAX_INFLIGHT))
        else $error("Inflight count above limit");

    pop_underflow_check: assert property (@(posedge clk) disable iff (rst)
        pop |-> (inflight_count != '0))
        else $error("Pop with nothing in flight");

endmodule

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
// PC is forced word aligned; it moves only on a flush or an issued request with the flush first
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_flush,
    input  logic             new_request,
    input  fetch_pkg::addr_t flush_pc,
    output fetch_pkg::addr_t pc
);
    import fetch_pkg::*;

    addr_t pc_plus_4;
    addr_t next_pc;
    logic  update_pc;

    assign pc_plus_4 = pc + 32'd4;

    // Flush redirect wins over sequential advance
    assign next_pc = fetch_flush ? flush_pc : pc_plus_4;

    assign update_pc = fetch_flush | new_request;

    //////////////////////////////
    // PC register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (update_pc) begin
            pc <= {next_pc[31:2], 2'b00};
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
// Fixed address map with inclusive ranges that must not overlap; MAX_INFLIGHT also sets FIFO depth
`default_nettype none

package fetch_pkg;

    // Fetch address or instruction word
    typedef logic [31:0] addr_t;

    // Source selector where 0 is local memory and 1 is the bus
    typedef logic unit_sel_t;

    //////////////////////////////
    // Address map
    localparam addr_t RESET_VEC = 32'h0000_0000;

    localparam addr_t LMEM_BASE = 32'h0000_0000;
    localparam addr_t LMEM_LAST = 32'h0000_0FFF;

    localparam addr_t IBUS_BASE = 32'h8000_0000;
    localparam addr_t IBUS_LAST = 32'h8000_FFFF;

    // Word address width of the 4 KB local block RAM
    localparam int LMEM_AW = 10;

    //////////////////////////////
    // Request tracking
    localparam int MAX_INFLIGHT = 2;
    localparam int INFLIGHT_W   = $clog2(MAX_INFLIGHT + 1);

    localparam unit_sel_t UNIT_LMEM = 1'b0;
    localparam unit_sel_t UNIT_IBUS = 1'b1;

    // One entry per issued or faulted fetch in issue order
    typedef struct packed {
        addr_t     pc;
        logic      address_valid;
        unit_sel_t unit_sel;
    } fetch_attr_t;

endpackage

`default_nettype wire

//--- verilog/fetch_top.sv
// Inputs are sampled on the rising edge; bus completions are combinational with bus_ack
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_flush,
    input  fetch_pkg::addr_t              flush_pc,
    input  logic                          fetch_hold,
    output logic                          fetch_complete,
    output fetch_pkg::addr_t              fetch_pc,
    output fetch_pkg::addr_t              fetch_instruction,
    output logic                          fetch_ok,
    output logic                          bram_en,
    output logic [fetch_pkg::LMEM_AW-1:0] bram_addr,
    input  fetch_pkg::addr_t              bram_data,
    output logic                          bus_req,
    output fetch_pkg::addr_t              bus_addr,
    input  logic                          bus_ack,
    input  fetch_pkg::addr_t              bus_data
);
    import fetch_pkg::*;

    addr_t       pc;
    logic        new_request;
    logic        fault_push;
    logic        fifo_push;
    logic        pop;
    logic        discard;
    logic        fifo_full;
    logic        fifo_valid;
    fetch_attr_t attr_in;
    fetch_attr_t head;

    logic  lmem_request;
    logic  lmem_ready;
    logic  lmem_data_valid;
    addr_t lmem_data;
    logic  ibus_request;
    logic  ibus_ready;
    logic  ibus_data_valid;
    addr_t ibus_data;

    // Faults occupy a FIFO slot like any request
    assign fifo_push = new_request | fault_push;

    //////////////////////////////
    // Core fetch logic
    fetch_pc_gen pc_gen0 (
        .clk         (clk),
        .rst         (rst),
        .fetch_flush (fetch_flush),
        .new_request (new_request),
        .flush_pc    (flush_pc),
        .pc          (pc)
    );

    fetch_control ctrl0 (
        .clk               (clk),
        .rst               (rst),
        .fetch_flush       (fetch_flush),
        .fetch_hold        (fetch_hold),
        .fifo_full         (fifo_full),
        .fifo_valid        (fifo_valid),
        .lmem_ready        (lmem_ready),
        .ibus_ready        (ibus_ready),
        .lmem_data_valid   (lmem_data_valid),
        .ibus_data_valid   (ibus_data_valid),
        .discard           (discard),
        .pc                (pc),
        .lmem_data         (lmem_data),
        .ibus_data         (ibus_data),
        .head              (head),
        .new_request       (new_request),
        .fault_push        (fault_push),
        .pop               (pop),
        .lmem_request      (lmem_request),
        .ibus_request      (ibus_request),
        .attr_in           (attr_in),
        .fetch_complete    (fetch_complete),
        .fetch_ok          (fetch_ok),
        .fetch_pc          (fetch_pc),
        .fetch_instruction (fetch_instruction)
    );

    fetch_inflight_counter count0 (
        .clk         (clk),
        .rst         (rst),
        .push        (fifo_push),
        .pop         (pop),
        .fetch_flush (fetch_flush),
        .discard     (discard)
    );

    fetch_attr_fifo #(
        .payload_t (fetch_attr_t),
        .DEPTH     (MAX_INFLIGHT)
    ) attr_fifo0 (
        .clk      (clk),
        .rst      (rst),
        .push     (fifo_push),
        .pop      (pop),
        .data_in  (attr_in),
        .data_out (head),
        .full     (fifo_full),
        .valid    (fifo_valid)
    );

    //////////////////////////////
    // Instruction sources
    ilocal_mem_unit lmem0 (
        .clk        (clk),
        .rst        (rst),
        .request    (lmem_request),
        .addr       (pc),
        .bram_data  (bram_data),
        .bram_en    (bram_en),
        .bram_addr  (bram_addr),
        .ready      (lmem_ready),
        .data_valid (lmem_data_valid),
        .data_out   (lmem_data)
    );

    ibus_unit ibus0 (
        .clk        (clk),
        .rst        (rst),
        .request    (ibus_request),
        .addr       (pc),
        .bus_ack    (bus_ack),
        .bus_data   (bus_data),
        .bus_req    (bus_req),
        .bus_addr   (bus_addr),
        .ready      (ibus_ready),
        .data_valid (ibus_data_valid),
        .data_out   (ibus_data)
    );

endmodule

`default_nettype wire

//--- verilog/ibus_unit.sv
// One request outstanding; the bus must not ack unless a request is pending
`timescale 1ns/100ps
`default_nettype none

module ibus_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             request,
    input  fetch_pkg::addr_t addr,
    input  logic             bus_ack,
    input  fetch_pkg::addr_t bus_data,
    output logic             bus_req,
    output fetch_pkg::addr_t bus_addr,
    output logic             ready,
    output logic             data_valid,
    output fetch_pkg::addr_t data_out
);
    logic busy;

    // Busy blocks new issues so responses stay in order
    assign ready      = ~busy;
    assign data_valid = bus_ack;
    assign data_out   = bus_data;

    //////////////////////////////
    // Request tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bus_req <= 1'b0;
        end else begin
            bus_req <= request;
            if (request) begin
                busy <= 1'b1;
            end else if (bus_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // Address held until the next request
    always_ff @(posedge clk) begin
        if (request) begin
            bus_addr <= addr;
        end
    end

    ack_idle_check: assert property (@(posedge clk) disable iff (rst) bus_ack |-> busy)
        else $error("Bus ack while unit is idle");

endmodule

`default_nettype wire

//--- verilog/ilocal_mem_unit.sv
// Block RAM must return data exactly one cycle after bram_en; addresses outside the range alias
`timescale 1ns/100ps
`default_nettype none

module ilocal_mem_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          request,
    input  fetch_pkg::addr_t              addr,
    input  fetch_pkg::addr_t              bram_data,
    output logic                          bram_en,
    output logic [fetch_pkg::LMEM_AW-1:0] bram_addr,
    output logic                          ready,
    output logic                          data_valid,
    output fetch_pkg::addr_t              data_out
);
    import fetch_pkg::*;

    addr_t offset;

    // Byte offset into the RAM window, then word index
    assign offset    = addr - LMEM_BASE;
    assign bram_en   = request;
    assign bram_addr = offset[LMEM_AW+1:2];

    // Fixed latency, so back-to-back reads need no stall
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= request;
        end
    end

    assign data_out = bram_data;

endmodule

`default_nettype wire
